/* sd_defs.svh */
`ifndef SD_DEFS_SVH
`define SD_DEFS_SVH

// ====================
// Frame sizes
// ====================
`define SD_CMD_BITS 48
`define SD_RESP_BITS 48

// Four-bit data bus
`define SD_DAT_LANES 4
`define SD_DAT_BLOCK_NIBBLES 128

// ====================
// CRC polynomials, top term implied
// ====================
`define SD_CRC7_POLY 7'h09
`define SD_CRC16_BITS 16
`define SD_CRC16_POLY 16'h1021

// CMD input reads high this long after the host lets go of the line
`define SD_TURNAROUND_CYCLES 2

`endif

/* sd_pkg.sv */
`default_nettype none

`include "sd_defs.svh"

package sd_pkg;

    // ====================
    // Field types
    // ====================
    typedef logic [5:0] sd_cmd_index_t;
    typedef logic [31:0] sd_arg_t;
    typedef logic [6:0] sd_crc7_t;
    typedef logic [`SD_CRC16_BITS-1:0] sd_crc16_t;
    typedef logic [`SD_CMD_BITS-1:0] sd_frame_t;
    typedef logic [`SD_DAT_LANES-1:0] sd_nibble_t;
    typedef logic [`SD_DAT_LANES-1:0] sd_lane_mask_t;

    typedef enum logic {
        SD_RESP_NONE,
        SD_RESP_48
    } sd_resp_type_e;

    // ====================
    // Bundles
    // ====================
    // Head of the command frame plus what to expect back
    typedef struct packed {
        sd_cmd_index_t index;
        sd_arg_t arg;
        sd_resp_type_e resp_type;
        logic dat_in;
    } sd_cmd_req_t;

    typedef struct packed {
        sd_frame_t frame;
        logic crc_err;
        logic end_err;
    } sd_resp_t;

    // Block phase strobes, one of them high in every cycle
    typedef struct packed {
        logic clear;
        logic payload;
        logic crc_cmp;
        logic end_cmp;
    } sd_dat_phase_t;

    typedef struct packed {
        sd_lane_mask_t lane_err;
        logic end_err;
    } sd_dat_result_t;

    // ====================
    // State machines
    // ====================
    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_LOAD,
        CMD_HEAD,
        CMD_CRC,
        CMD_END
    } cmd_state_e;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_WAIT,
        RESP_CAPTURE
    } resp_state_e;

    typedef enum logic [2:0] {
        DAT_IDLE,
        DAT_WAIT,
        DAT_PAYLOAD,
        DAT_CRC,
        DAT_END
    } dat_state_e;

endpackage

`default_nettype wire

/* sd_crc7.sv */
`default_nettype none

`include "sd_defs.svh"

// Serial CRC7, MSB of the frame first
module sd_crc7 (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire logic clear,
    input wire logic enable,
    input wire logic din,
    output sd_pkg::sd_crc7_t crc
);

    logic feedback;

    // Feeding crc[6] back as din gives zero feedback,
    // so the register then simply shifts its CRC out
    assign feedback = din ^ crc[6];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= (crc << 1) ^ ({7{feedback}} & `SD_CRC7_POLY);
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_engine.sv */
`default_nettype none

`include "sd_defs.svh"

module sd_cmd_engine (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire logic cmd_start,
    input wire sd_pkg::sd_cmd_req_t cmd_req,
    output logic cmd_done,
    output logic resp_done,
    output sd_pkg::sd_resp_t resp,
    output logic dat_arm,
    output logic sd_cmd_out,
    output logic sd_cmd_oe,
    input wire logic sd_cmd_in
);

    // Start, transmission bit, index and argument
    localparam int HEAD_BITS = `SD_CMD_BITS - 8;
    // CRC7 and end bit at the tail of a frame
    localparam int TAIL_BITS = 8;
    localparam int CNT_W = $clog2(`SD_CMD_BITS);
    localparam int TA = `SD_TURNAROUND_CYCLES;

    sd_pkg::cmd_state_e cmd_state;
    logic [CNT_W-1:0] cmd_cnt;
    logic [HEAD_BITS-1:0] cmd_sr;
    sd_pkg::sd_crc7_t cmd_crc;
    logic cmd_finish;

    sd_pkg::resp_state_e resp_state;
    logic [CNT_W-1:0] resp_cnt;
    sd_pkg::sd_frame_t resp_sr;
    sd_pkg::sd_crc7_t resp_crc;
    logic resp_crc_en;
    logic [TA-1:0] turn_sr;
    logic cmd_in_q;

    // ====================
    // Command out
    // ====================
    assign cmd_finish = (cmd_state == sd_pkg::CMD_END);

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            cmd_state <= sd_pkg::CMD_IDLE;
            cmd_cnt <= '0;
            cmd_done <= 1'b0;
            dat_arm <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            dat_arm <= 1'b0;
            cmd_cnt <= cmd_cnt - 1'b1;
            case (cmd_state)
                sd_pkg::CMD_LOAD: begin
                    cmd_cnt <= CNT_W'(HEAD_BITS - 1);
                    cmd_state <= sd_pkg::CMD_HEAD;
                end
                sd_pkg::CMD_HEAD: begin
                    if (cmd_cnt == '0) begin
                        cmd_cnt <= CNT_W'(6);
                        cmd_state <= sd_pkg::CMD_CRC;
                    end
                end
                sd_pkg::CMD_CRC: begin
                    if (cmd_cnt == '0) begin
                        cmd_state <= sd_pkg::CMD_END;
                    end
                end
                sd_pkg::CMD_END: begin
                    cmd_done <= 1'b1;
                    dat_arm <= cmd_req.dat_in;
                    cmd_state <= sd_pkg::CMD_IDLE;
                end
                default: begin
                    cmd_state <= sd_pkg::CMD_IDLE;
                end
            endcase
            if (cmd_start) begin
                cmd_state <= sd_pkg::CMD_LOAD;
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (cmd_state == sd_pkg::CMD_LOAD) begin
            cmd_sr <= {2'b01, cmd_req.index, cmd_req.arg};
        end else if (cmd_state == sd_pkg::CMD_HEAD) begin
            cmd_sr <= cmd_sr << 1;
        end
    end

    assign sd_cmd_oe = cmd_state inside {sd_pkg::CMD_HEAD, sd_pkg::CMD_CRC, sd_pkg::CMD_END};

    always_comb begin
        case (cmd_state)
            sd_pkg::CMD_HEAD: sd_cmd_out = cmd_sr[HEAD_BITS-1];
            sd_pkg::CMD_CRC: sd_cmd_out = cmd_crc[6];
            default: sd_cmd_out = 1'b1;
        endcase
    end

    // Runs over the head, then shifts the CRC onto the line
    sd_crc7 sd_crc7_cmd_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .clear(cmd_state == sd_pkg::CMD_LOAD),
        .enable(cmd_state inside {sd_pkg::CMD_HEAD, sd_pkg::CMD_CRC}),
        .din(sd_cmd_out),
        .crc(cmd_crc)
    );

    // ====================
    // Response in
    // ====================
    // Line reads high while driven and for TA cycles after release
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            turn_sr <= '0;
            cmd_in_q <= 1'b1;
        end else begin
            turn_sr <= (turn_sr << 1) | TA'(sd_cmd_oe);
            cmd_in_q <= (sd_cmd_oe || (|turn_sr)) ? 1'b1 : sd_cmd_in;
        end
    end

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            resp_state <= sd_pkg::RESP_IDLE;
            resp_cnt <= '0;
            resp_done <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (resp_state)
                sd_pkg::RESP_WAIT: begin
                    resp_cnt <= CNT_W'(`SD_RESP_BITS - 1);
                    if (!cmd_in_q) begin
                        resp_state <= sd_pkg::RESP_CAPTURE;
                    end
                end
                sd_pkg::RESP_CAPTURE: begin
                    resp_cnt <= resp_cnt - 1'b1;
                    if (resp_cnt == '0) begin
                        resp_done <= 1'b1;
                        resp_state <= sd_pkg::RESP_IDLE;
                    end
                end
                default: begin
                    resp_state <= sd_pkg::RESP_IDLE;
                end
            endcase
            if (cmd_finish && cmd_req.resp_type == sd_pkg::SD_RESP_48) begin
                resp_state <= sd_pkg::RESP_WAIT;
            end
            if (cmd_start) begin
                resp_state <= sd_pkg::RESP_IDLE;
            end
        end
    end

    // Start bit goes in from WAIT, then 47 more bits
    always_ff @(posedge clk_fast) begin
        if (resp_state == sd_pkg::RESP_WAIT ||
                (resp_state == sd_pkg::RESP_CAPTURE && resp_cnt != '0)) begin
            resp_sr <= {resp_sr[`SD_RESP_BITS-2:0], cmd_in_q};
        end
        if (resp_state == sd_pkg::RESP_CAPTURE && resp_cnt == '0) begin
            resp.frame <= resp_sr;
            resp.crc_err <= (resp_crc != resp_sr[7:1]);
            resp.end_err <= !resp_sr[0];
        end
    end

    // Covers bits 47..8 only
    assign resp_crc_en = (resp_state == sd_pkg::RESP_WAIT && !cmd_in_q) ||
        (resp_state == sd_pkg::RESP_CAPTURE && resp_cnt > CNT_W'(TAIL_BITS));

    sd_crc7 sd_crc7_resp_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .clear(resp_state == sd_pkg::RESP_IDLE),
        .enable(resp_crc_en),
        .din(cmd_in_q),
        .crc(resp_crc)
    );

    // ====================
    // Checks
    // ====================
    a_released_in_capture: assert property (@(posedge clk_fast) disable iff (!arst_n)
        resp_state == sd_pkg::RESP_CAPTURE |-> !sd_cmd_oe);

    // New command only once the previous frame is out
    a_start_when_idle: assert property (@(posedge clk_fast) disable iff (!arst_n)
        cmd_start |-> cmd_state == sd_pkg::CMD_IDLE);

endmodule

`default_nettype wire

/* sd_dat_deserializer.sv */
`default_nettype none

`include "sd_defs.svh"

module sd_dat_deserializer (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire logic dat_arm,
    input wire logic abort,
    input wire sd_pkg::sd_nibble_t sd_dat_in,
    output sd_pkg::sd_dat_phase_t phase,
    output sd_pkg::sd_nibble_t lane_bits,
    output logic dat_valid,
    output sd_pkg::sd_nibble_t dat_data,
    output logic dat0_idle
);

    localparam int CNT_W = $clog2(`SD_DAT_BLOCK_NIBBLES);

    sd_pkg::dat_state_e dat_state;
    logic [CNT_W-1:0] dat_cnt;
    sd_pkg::sd_nibble_t dat_in_q;

    // Idle bus is pulled high
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            dat_in_q <= '1;
            dat0_idle <= 1'b1;
        end else begin
            dat_in_q <= sd_dat_in;
            dat0_idle <= dat_in_q[0];
        end
    end

    // ====================
    // Block sequencing
    // ====================
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            dat_state <= sd_pkg::DAT_IDLE;
            dat_cnt <= '0;
        end else begin
            dat_cnt <= dat_cnt - 1'b1;
            case (dat_state)
                sd_pkg::DAT_WAIT: begin
                    dat_cnt <= CNT_W'(`SD_DAT_BLOCK_NIBBLES - 1);
                    // Start bit on all four lanes together
                    if (dat_in_q == '0) begin
                        dat_state <= sd_pkg::DAT_PAYLOAD;
                    end
                end
                sd_pkg::DAT_PAYLOAD: begin
                    if (dat_cnt == '0) begin
                        dat_cnt <= CNT_W'(`SD_CRC16_BITS - 1);
                        dat_state <= sd_pkg::DAT_CRC;
                    end
                end
                sd_pkg::DAT_CRC: begin
                    if (dat_cnt == '0) begin
                        dat_state <= sd_pkg::DAT_END;
                    end
                end
                default: begin
                    dat_state <= sd_pkg::DAT_IDLE;
                end
            endcase
            if (dat_arm) begin
                dat_state <= sd_pkg::DAT_WAIT;
            end
            if (abort) begin
                dat_state <= sd_pkg::DAT_IDLE;
            end
        end
    end

    // Clear holds the lane checkers while nothing is in flight
    always_comb begin
        phase.clear = dat_state inside {sd_pkg::DAT_IDLE, sd_pkg::DAT_WAIT};
        phase.payload = (dat_state == sd_pkg::DAT_PAYLOAD);
        phase.crc_cmp = (dat_state == sd_pkg::DAT_CRC);
        phase.end_cmp = (dat_state == sd_pkg::DAT_END);
    end

    assign lane_bits = dat_in_q;
    assign dat_valid = phase.payload;
    assign dat_data = dat_in_q;

    // A new block is only armed once the previous one is finished or aborted
    a_arm_when_idle: assert property (@(posedge clk_fast) disable iff (!arst_n)
        dat_arm |-> dat_state == sd_pkg::DAT_IDLE);

endmodule

`default_nettype wire

/* sd_dat_lane_crc.sv */
`default_nettype none

`include "sd_defs.svh"

// CRC16 of one DAT lane, checked against the card's CRC bit by bit
module sd_dat_lane_crc (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire sd_pkg::sd_dat_phase_t phase,
    input wire logic din,
    output logic crc_err
);

    sd_pkg::sd_crc16_t crc;
    logic feedback;

    assign feedback = din ^ crc[`SD_CRC16_BITS-1];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
            crc_err <= 1'b0;
        end else if (phase.clear) begin
            crc <= '0;
            crc_err <= 1'b0;
        end else if (phase.payload) begin
            crc <= (crc << 1) ^ ({`SD_CRC16_BITS{feedback}} & `SD_CRC16_POLY);
        end else if (phase.crc_cmp) begin
            // Received bit against our MSB, then move to the next one
            crc <= crc << 1;
            if (feedback) begin
                crc_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sd_dat_collector.sv */
`default_nettype none

module sd_dat_collector (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire sd_pkg::sd_dat_phase_t phase,
    input wire sd_pkg::sd_nibble_t end_bits,
    input wire sd_pkg::sd_lane_mask_t lane_err,
    output logic dat_done,
    output sd_pkg::sd_dat_result_t dat_result
);

    logic end_err;

    // Every lane must close with a 1
    assign end_err = !(&end_bits);

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            dat_done <= 1'b0;
        end else begin
            dat_done <= phase.end_cmp;
        end
    end

    // Lane errors are final by the end-bit cycle
    always_ff @(posedge clk_fast) begin
        if (phase.end_cmp) begin
            dat_result.lane_err <= lane_err;
            dat_result.end_err <= end_err;
        end
    end

    // ====================
    // Checks
    // ====================
    a_end_after_crc: assert property (@(posedge clk_fast) disable iff (!arst_n)
        phase.end_cmp |-> $past(phase.crc_cmp));

    // Lane checkers enter a block with no stale error
    a_clean_start: assert property (@(posedge clk_fast) disable iff (!arst_n)
        $rose(phase.payload) |-> lane_err == '0);

endmodule

`default_nettype wire

/* sd_host_top.sv */
`default_nettype none

`include "sd_defs.svh"

module sd_host_top (
    input wire logic clk_fast,
    input wire logic arst_n,
    input wire logic cmd_start,
    input wire sd_pkg::sd_cmd_req_t cmd_req,
    output logic cmd_done,
    output logic resp_done,
    output sd_pkg::sd_resp_t resp,
    output logic dat_valid,
    output sd_pkg::sd_nibble_t dat_data,
    output logic dat_done,
    output sd_pkg::sd_dat_result_t dat_result,
    output logic dat0_idle,
    output logic sd_cmd_out,
    output logic sd_cmd_oe,
    input wire logic sd_cmd_in,
    input wire sd_pkg::sd_nibble_t sd_dat_in
);

    logic dat_arm;
    sd_pkg::sd_dat_phase_t phase;
    sd_pkg::sd_nibble_t lane_bits;
    sd_pkg::sd_lane_mask_t lane_err;

    sd_cmd_engine sd_cmd_engine_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .cmd_start(cmd_start),
        .cmd_req(cmd_req),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp(resp),
        .dat_arm(dat_arm),
        .sd_cmd_out(sd_cmd_out),
        .sd_cmd_oe(sd_cmd_oe),
        .sd_cmd_in(sd_cmd_in)
    );

    // A new command cancels any armed block
    sd_dat_deserializer sd_dat_deserializer_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .dat_arm(dat_arm),
        .abort(cmd_start),
        .sd_dat_in(sd_dat_in),
        .phase(phase),
        .lane_bits(lane_bits),
        .dat_valid(dat_valid),
        .dat_data(dat_data),
        .dat0_idle(dat0_idle)
    );

    for (genvar i = 0; i < `SD_DAT_LANES; i++) begin : g_lane
        sd_dat_lane_crc sd_dat_lane_crc_i (
            .clk_fast(clk_fast),
            .arst_n(arst_n),
            .phase(phase),
            .din(lane_bits[i]),
            .crc_err(lane_err[i])
        );
    end

    sd_dat_collector sd_dat_collector_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .phase(phase),
        .end_bits(lane_bits),
        .lane_err(lane_err),
        .dat_done(dat_done),
        .dat_result(dat_result)
    );

endmodule

`default_nettype wire

/* tb_sd_card.sv */
`default_nettype none

`include "sd_defs.svh"

// Card side of the bus, replies the way the testbench scripts it
module tb_sd_card (
    input wire logic clk_fast,
    input wire logic sd_cmd_oe,
    output logic sd_cmd_in,
    output sd_pkg::sd_nibble_t sd_dat_in,
    input wire logic resp_en,
    input wire sd_pkg::sd_frame_t resp_frame,
    input wire logic dat_en,
    input wire logic [`SD_DAT_BLOCK_NIBBLES*`SD_DAT_LANES-1:0] dat_block,
    input wire logic [`SD_DAT_LANES*`SD_CRC16_BITS-1:0] dat_crc,
    input wire sd_pkg::sd_nibble_t dat_end,
    input wire logic [7:0] reply_delay,
    input wire logic dat0_level,
    output logic busy
);
    timeunit 1ns;
    timeprecision 1ps;

    logic oe_q;

    // Response frame MSB first, line back high afterwards
    task automatic drive_response();
        int i;
        for (i = `SD_RESP_BITS - 1; i >= 0; i--) begin
            sd_cmd_in <= resp_frame[i];
            @(negedge clk_fast);
        end
        sd_cmd_in <= 1'b1;
    endtask

    // Start nibble, payload, per-lane CRC16 and end bits
    task automatic stream_block();
        int i;
        int lane;
        sd_pkg::sd_nibble_t nib;
        sd_dat_in <= '0;
        @(negedge clk_fast);
        for (i = 0; i < `SD_DAT_BLOCK_NIBBLES; i++) begin
            sd_dat_in <= dat_block[i*`SD_DAT_LANES +: `SD_DAT_LANES];
            @(negedge clk_fast);
        end
        for (i = 0; i < `SD_CRC16_BITS; i++) begin
            for (lane = 0; lane < `SD_DAT_LANES; lane++) begin
                nib[lane] = dat_crc[lane*`SD_CRC16_BITS + `SD_CRC16_BITS - 1 - i];
            end
            sd_dat_in <= nib;
            @(negedge clk_fast);
        end
        sd_dat_in <= dat_end;
        @(negedge clk_fast);
        sd_dat_in <= {3'b111, dat0_level};
    endtask

    task automatic answer_command();
        busy <= 1'b1;
        repeat (reply_delay) @(negedge clk_fast);
        if (resp_en) begin
            drive_response();
            repeat (reply_delay) @(negedge clk_fast);
        end
        if (dat_en) begin
            stream_block();
        end
        // Short quiet tail so the host side can drain
        repeat (4) @(negedge clk_fast);
        busy <= 1'b0;
    endtask

    // ====================
    // Bus watcher
    // ====================
    initial begin
        sd_cmd_in = 1'b1;
        sd_dat_in = '1;
        busy = 1'b0;
        oe_q = 1'b0;
        forever begin
            @(negedge clk_fast);
            // Host releasing CMD marks the end of a command
            if (oe_q && !sd_cmd_oe) begin
                answer_command();
            end else begin
                sd_dat_in <= {3'b111, dat0_level};
            end
            oe_q = sd_cmd_oe;
        end
    end

endmodule

`default_nettype wire

/* tb_sd_host.sv */
`default_nettype none

`include "sd_defs.svh"

module tb_sd_host;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CMDS = 40;
    localparam int NIB = `SD_DAT_BLOCK_NIBBLES;
    localparam int CMD_DONE_NEG = `SD_CMD_BITS + 2;
    localparam int CMD_LIMIT = 60;
    localparam int REPLY_LIMIT = 1000;

    logic clk_fast;
    logic arst_n;
    logic cmd_start;
    sd_pkg::sd_cmd_req_t cmd_req;
    logic cmd_done;
    logic resp_done;
    sd_pkg::sd_resp_t resp;
    logic dat_valid;
    sd_pkg::sd_nibble_t dat_data;
    logic dat_done;
    sd_pkg::sd_dat_result_t dat_result;
    logic dat0_idle;
    logic sd_cmd_out;
    logic sd_cmd_oe;
    logic sd_cmd_in;
    sd_pkg::sd_nibble_t sd_dat_in;

    // Card script
    logic resp_en;
    sd_pkg::sd_frame_t resp_frame;
    logic dat_en;
    logic [NIB*`SD_DAT_LANES-1:0] dat_block;
    logic [`SD_DAT_LANES*`SD_CRC16_BITS-1:0] dat_crc;
    sd_pkg::sd_nibble_t dat_end;
    logic [7:0] reply_delay;
    logic dat0_level;
    logic card_busy;

    // Reference model
    integer seed;
    int n;
    sd_pkg::sd_frame_t exp_frame;
    sd_pkg::sd_resp_t exp_resp;
    sd_pkg::sd_dat_result_t exp_result;
    logic [NIB*`SD_DAT_LANES-1:0] exp_block;
    logic exp_resp48;
    logic exp_data;
    logic withheld;

    sd_host_top sd_host_top_i (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .cmd_start(cmd_start),
        .cmd_req(cmd_req),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp(resp),
        .dat_valid(dat_valid),
        .dat_data(dat_data),
        .dat_done(dat_done),
        .dat_result(dat_result),
        .dat0_idle(dat0_idle),
        .sd_cmd_out(sd_cmd_out),
        .sd_cmd_oe(sd_cmd_oe),
        .sd_cmd_in(sd_cmd_in),
        .sd_dat_in(sd_dat_in)
    );

    tb_sd_card sd_card_i (
        .clk_fast(clk_fast),
        .sd_cmd_oe(sd_cmd_oe),
        .sd_cmd_in(sd_cmd_in),
        .sd_dat_in(sd_dat_in),
        .resp_en(resp_en),
        .resp_frame(resp_frame),
        .dat_en(dat_en),
        .dat_block(dat_block),
        .dat_crc(dat_crc),
        .dat_end(dat_end),
        .reply_delay(reply_delay),
        .dat0_level(dat0_level),
        .busy(card_busy)
    );

    initial begin
        clk_fast = 1'b0;
        forever #50 clk_fast = ~clk_fast;
    end

    // ====================
    // CRC model
    // ====================
    function automatic sd_pkg::sd_crc7_t calc_crc7(input logic [39:0] head);
        sd_pkg::sd_crc7_t c;
        logic fb;
        int i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = head[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ `SD_CRC7_POLY;
            end
        end
        return c;
    endfunction

    // x^16 + x^12 + x^5 + 1 over one lane of the block
    function automatic sd_pkg::sd_crc16_t lane_crc16(input logic [NIB*`SD_DAT_LANES-1:0] block,
            input int lane);
        sd_pkg::sd_crc16_t c;
        logic fb;
        int i;
        c = '0;
        for (i = 0; i < NIB; i++) begin
            fb = block[i*`SD_DAT_LANES + lane] ^ c[`SD_CRC16_BITS-1];
            c = {c[`SD_CRC16_BITS-2:0], 1'b0};
            if (fb) begin
                c = c ^ `SD_CRC16_POLY;
            end
        end
        return c;
    endfunction

    // ====================
    // Failure reporting and compares
    // ====================
    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("At %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_frame(input string name, input sd_pkg::sd_frame_t got,
            input sd_pkg::sd_frame_t want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input sd_pkg::sd_resp_t got,
            input sd_pkg::sd_resp_t want);
        if (got !== want) begin
            $display({"** Error at %0t ns: %s is frame %h crc_err %b end_err %b, ",
                "expected frame %h crc_err %b end_err %b"},
                $time, name, got.frame, got.crc_err, got.end_err,
                want.frame, want.crc_err, want.end_err);
            stop_run();
        end
    endtask

    task automatic check_nibble(input string name, input sd_pkg::sd_nibble_t got,
            input sd_pkg::sd_nibble_t want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_dat_result(input string name, input sd_pkg::sd_dat_result_t got,
            input sd_pkg::sd_dat_result_t want);
        if (got !== want) begin
            $display({"** Error at %0t ns: %s is lane_err %b end_err %b, ",
                "expected lane_err %b end_err %b"},
                $time, name, got.lane_err, got.end_err, want.lane_err, want.end_err);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic prepare_command();
        sd_pkg::sd_cmd_req_t req;
        logic [39:0] head;
        sd_pkg::sd_frame_t rframe;
        logic crc_flip;
        logic end_bad;
        logic withhold;
        logic stray;
        sd_pkg::sd_lane_mask_t flip_mask;
        sd_pkg::sd_nibble_t end_zero;
        sd_pkg::sd_crc16_t c;
        logic [`SD_DAT_LANES*`SD_CRC16_BITS-1:0] crcs;
        int i;
        int pos;
        req.index = sd_pkg::sd_cmd_index_t'($random(seed));
        req.arg = $random(seed);
        req.resp_type = (($random(seed) & 3) != 0) ? sd_pkg::SD_RESP_48 : sd_pkg::SD_RESP_NONE;
        // After a withheld block the card sends one the host did not ask for
        stray = withheld;
        req.dat_in = stray ? 1'b0 : (($random(seed) & 1) != 0);
        withhold = req.dat_in && (($random(seed) & 7) == 0);
        head = {2'b01, req.index, req.arg};
        exp_frame = {head, calc_crc7(head), 1'b1};

        rframe = {2'b00, req.index, 32'($random(seed)), 7'h00, 1'b1};
        rframe[7:1] = calc_crc7(rframe[47:8]);
        crc_flip = ($random(seed) & 7) == 0;
        end_bad = ($random(seed) & 7) == 0;
        if (crc_flip) begin
            pos = ($random(seed) & 255) % 7;
            rframe[pos+1] = !rframe[pos+1];
        end
        if (end_bad) begin
            rframe[0] = 1'b0;
        end
        exp_resp.frame = rframe;
        exp_resp.crc_err = crc_flip;
        exp_resp.end_err = end_bad;

        for (i = 0; i < NIB; i++) begin
            exp_block[i*`SD_DAT_LANES +: `SD_DAT_LANES] = sd_pkg::sd_nibble_t'($random(seed));
        end
        flip_mask = (($random(seed) & 3) == 0) ? sd_pkg::sd_lane_mask_t'($random(seed)) : '0;
        end_zero = (($random(seed) & 3) == 0) ? sd_pkg::sd_nibble_t'($random(seed)) : '0;
        for (i = 0; i < `SD_DAT_LANES; i++) begin
            c = lane_crc16(exp_block, i);
            if (flip_mask[i]) begin
                pos = ($random(seed) & 255) % `SD_CRC16_BITS;
                c[pos] = !c[pos];
            end
            crcs[i*`SD_CRC16_BITS +: `SD_CRC16_BITS] = c;
        end
        exp_result.lane_err = flip_mask;
        exp_result.end_err = |end_zero;
        exp_resp48 = (req.resp_type == sd_pkg::SD_RESP_48);
        exp_data = req.dat_in && !withhold;
        withheld = withhold;

        cmd_req <= req;
        resp_en <= exp_resp48;
        resp_frame <= rframe;
        dat_en <= exp_data || stray;
        dat_block <= exp_block;
        dat_crc <= crcs;
        dat_end <= ~end_zero;
        reply_delay <= 8'(3 + ($random(seed) & 7));
        cmd_start <= 1'b1;
    endtask

    task automatic run_command();
        sd_pkg::sd_frame_t got;
        int bits;
        int cyc;
        int resp_cnt;
        int nib_cnt;
        int done_cnt;
        got = '0;
        bits = 0;
        cyc = 1;
        @(negedge clk_fast);
        cmd_start <= 1'b0;
        while (!cmd_done && cyc <= CMD_LIMIT) begin
            if (sd_cmd_oe) begin
                got = {got[`SD_CMD_BITS-2:0], sd_cmd_out};
                bits++;
            end
            @(negedge clk_fast);
            cyc++;
        end
        if (!cmd_done) report_failure("cmd_done never came after cmd_start");
        if (cyc != CMD_DONE_NEG) report_failure("cmd_done pulsed at the wrong cycle");
        if (bits != `SD_CMD_BITS) report_failure("sd_cmd_oe was high for the wrong number of bits");
        check_frame("sd_cmd_out", got, exp_frame);

        // Card reply window
        resp_cnt = 0;
        nib_cnt = 0;
        done_cnt = 0;
        cyc = 0;
        @(negedge clk_fast);
        while (card_busy && cyc < REPLY_LIMIT) begin
            if (resp_done) begin
                resp_cnt++;
                if (exp_resp48) check_resp("resp", resp, exp_resp);
            end
            if (dat_valid) begin
                if (exp_data && nib_cnt < NIB) begin
                    check_nibble("dat_data", dat_data,
                        exp_block[nib_cnt*`SD_DAT_LANES +: `SD_DAT_LANES]);
                end
                nib_cnt++;
            end
            if (dat_done) begin
                done_cnt++;
                if (exp_data) check_dat_result("dat_result", dat_result, exp_result);
            end
            @(negedge clk_fast);
            cyc++;
        end
        if (card_busy) report_failure("card reply did not finish in time");
        if (resp_cnt != (exp_resp48 ? 1 : 0)) report_failure("wrong number of resp_done pulses");
        if (nib_cnt != (exp_data ? NIB : 0)) report_failure("wrong number of payload nibbles");
        if (done_cnt != (exp_data ? 1 : 0)) report_failure("wrong number of dat_done pulses");
    endtask

    task automatic check_idle_level();
        logic level;
        level = ($random(seed) & 1) != 0;
        dat0_level <= level;
        repeat (4) @(negedge clk_fast);
        check_level("dat0_idle", dat0_idle, level);
    endtask

    initial begin
        seed = 32'hd61c;
        arst_n = 1'b0;
        cmd_start = 1'b0;
        cmd_req = '0;
        resp_en = 1'b0;
        resp_frame = '0;
        dat_en = 1'b0;
        dat_block = '0;
        dat_crc = '0;
        dat_end = '1;
        reply_delay = 8'd3;
        dat0_level = 1'b1;
        withheld = 1'b0;
        repeat (4) @(negedge clk_fast);
        arst_n <= 1'b1;
        repeat (2) @(negedge clk_fast);
        for (n = 0; n < NUM_CMDS; n++) begin
            prepare_command();
            run_command();
            check_idle_level();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
sd_pkg.sv
sd_crc7.sv
sd_cmd_engine.sv
sd_dat_deserializer.sv
sd_dat_lane_crc.sv
sd_dat_collector.sv
sd_host_top.sv
tb_sd_card.sv
tb_sd_host.sv

/* Bender.yml */
package:
  name: sd_host

export_include_dirs:
  - .

sources:
  - sd_pkg.sv
  - sd_crc7.sv
  - sd_cmd_engine.sv
  - sd_dat_deserializer.sv
  - sd_dat_lane_crc.sv
  - sd_dat_collector.sv
  - sd_host_top.sv
  - target: test
    files:
      - tb_sd_card.sv
      - tb_sd_host.sv
